//--- Makefile
TOP := tb_soc_subsys
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f verilog.f

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/tb_soc_subsys.sv
// Testbench for the peripheral subsystem with bus driver task, RAM model, rtc driver and assertions
module tb_soc_subsys;

  localparam int NumHarts   = 2;
  localparam int DebugDelay = 40;
  localparam int ClkPeriod  = 8;
  localparam int Seed       = 70338;
  localparam int RomWords   = 16;
  localparam int RamSlots   = 16;
  localparam int RtcPairs   = 4;

  // Address map as seen from the bus master
  localparam logic [31:0] RomBase     = 32'h0001_0000;
  localparam logic [31:0] ClintBase   = 32'h0200_0000;
  localparam logic [31:0] RamBase     = 32'h8000_0000;
  localparam logic [31:0] MtimeLo     = ClintBase + 32'h0000_BFF8;
  localparam logic [31:0] MtimecmpLo  = ClintBase + 32'h0000_4000;

  // --------------------------------------------------
  // Cycle budget
  // --------------------------------------------------
  localparam int LenReset      = 60;
  localparam int LenRom        = 60;
  localparam int LenRam        = 200;
  localparam int LenUnmapped   = 30;
  localparam int LenClint      = 320;
  localparam int TimeoutCycles = 2 * (LenReset + LenRom + LenRam + LenUnmapped + LenClint);

  typedef enum logic [1:0] {
    RespNone = 2'd0,
    RespAck  = 2'd1,
    RespErr  = 2'd2
  } resp_e;

  logic                clk_i;
  logic                ndmreset_n;
  logic                rtc_i;
  logic                wb_cyc_i;
  logic                wb_stb_i;
  logic                wb_we_i;
  logic [31:0]         wb_adr_i;
  logic [31:0]         wb_dat_i;
  logic [3:0]          wb_sel_i;
  logic [31:0]         wb_dat_o;
  logic                wb_ack_o;
  logic                wb_err_o;
  logic [NumHarts-1:0] debug_req_i;
  logic [NumHarts-1:0] debug_req_o;
  logic [NumHarts-1:0] timer_irq_o;
  logic [NumHarts-1:0] ipi_o;

  logic [31:0] rom_image [RomWords];
  int          errors;
  int          proto_errors;
  int          checks;
  int          tests_run;
  bit          rtc_run;
  int          rtc_rises;

  soc_subsys_top #(
    .NUM_HARTS          ( NumHarts   ),
    .DEBUG_DELAY_CYCLES ( DebugDelay )
  ) i_dut (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .wb_cyc_i    ( wb_cyc_i    ),
    .wb_stb_i    ( wb_stb_i    ),
    .wb_we_i     ( wb_we_i     ),
    .wb_adr_i    ( wb_adr_i    ),
    .wb_dat_i    ( wb_dat_i    ),
    .wb_sel_i    ( wb_sel_i    ),
    .wb_dat_o    ( wb_dat_o    ),
    .wb_ack_o    ( wb_ack_o    ),
    .wb_err_o    ( wb_err_o    ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  // rtc with a period of 10 clocks while enabled
  initial begin : rtc_driver
    int phase;
    phase     = 0;
    rtc_i     = 1'b0;
    rtc_rises = 0;
    forever begin
      @(negedge clk_i);
      if (rtc_run) begin
        if (phase == 4) begin
          phase = 0;
          if (!rtc_i) begin
            rtc_rises++;
          end
          rtc_i = ~rtc_i;
        end else begin
          phase++;
        end
      end
    end
  end

  // --------------------------------------------------
  // Bus protocol checks
  // --------------------------------------------------
  ack_err_exclusive: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !(wb_ack_o && wb_err_o))
    else begin
      $display("Fail %0t: ack and err high together", $time);
      proto_errors++;
    end

  resp_one_clock: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    $rose(wb_stb_i) |=> (wb_ack_o || wb_err_o))
    else begin
      $display("Fail %0t: no response one clock after stb", $time);
      proto_errors++;
    end

  resp_single_cycle: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o))
    else begin
      $display("Fail %0t: response held for more than one cycle", $time);
      proto_errors++;
    end

  resp_needs_request: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (wb_ack_o || wb_err_o) |-> $past(wb_cyc_i && wb_stb_i))
    else begin
      $display("Fail %0t: response without a request", $time);
      proto_errors++;
    end

  // One Wishbone cycle, started on a falling edge, with one idle clock after it
  task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] wdata,
                           input logic [3:0] sel, output logic [31:0] rdata,
                           output resp_e resp);
    int waited;
    waited   = 0;
    resp     = RespNone;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    wb_sel_i = sel;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    while (resp == RespNone && waited < 4) begin
      @(negedge clk_i);
      waited++;
      if (wb_ack_o) begin
        resp = RespAck;
      end else if (wb_err_o) begin
        resp = RespErr;
      end
    end
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    if (resp == RespNone) begin
      $display("Bus cycle to address %h got no response within 4 clocks at time %0t",
               adr, $time);
      errors++;
    end
    @(negedge clk_i);
  endtask

  task automatic compare_word(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
    checks++;
    assert (got === exp)
      else begin
        $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        errors++;
      end
  endtask

  task automatic check_within(input string what, input logic [63:0] got,
                              input logic [63:0] lo, input logic [63:0] hi);
    checks++;
    assert (got >= lo && got <= hi)
      else begin
        $display("Fail %0t: %s got %0d outside %0d to %0d", $time, what, got, lo, hi);
        errors++;
      end
  endtask

  task automatic report_test(input string name, input int errors_before);
    int new_errors;
    new_errors = errors + proto_errors - errors_before;
    tests_run++;
    if (new_errors == 0) begin
      $display("Test %s: done, no errors", name);
    end else begin
      $display("Test %s: done, %0d errors", name, new_errors);
    end
  endtask

  // Byte-lane merge of a write into the stored word
  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] sel);
    logic [31:0] merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  task automatic read_mtime(output logic [63:0] value);
    logic [31:0] lo;
    logic [31:0] hi;
    resp_e       resp;
    bus_cycle(1'b0, MtimeLo, '0, 4'hF, lo, resp);
    bus_cycle(1'b0, MtimeLo + 32'd4, '0, 4'hF, hi, resp);
    value = {hi, lo};
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------
  task automatic reset_and_debug_gate();
    int err_start;
    err_start = errors + proto_errors;
    compare_word("ack after reset", 64'(wb_ack_o), 64'(0));
    compare_word("err after reset", 64'(wb_err_o), 64'(0));
    compare_word("timer_irq_o after reset", 64'(timer_irq_o), 64'(0));
    compare_word("ipi_o after reset", 64'(ipi_o), 64'(0));
    // Margin of 3 clocks on both sides of the delay
    for (int i = 0; i <= DebugDelay + 6; i++) begin
      if (i <= DebugDelay - 3) begin
        compare_word($sformatf("debug_req_o %0d clocks after reset", i),
                     64'(debug_req_o), 64'(0));
      end else if (i >= DebugDelay + 3) begin
        compare_word($sformatf("debug_req_o %0d clocks after reset", i),
                     64'(debug_req_o), 64'(debug_req_i));
      end
      @(negedge clk_i);
    end
    for (int n = 0; n < 8; n++) begin
      debug_req_i = NumHarts'($urandom);
      @(negedge clk_i);
      compare_word("debug_req_o following input", 64'(debug_req_o), 64'(debug_req_i));
    end
    report_test("reset and debug gate", err_start);
  endtask

  task automatic rom_reads();
    int          err_start;
    logic [31:0] rdata;
    resp_e       resp;
    err_start = errors + proto_errors;
    for (int i = 0; i < RomWords; i++) begin
      bus_cycle(1'b0, RomBase + 32'(4 * i), '0, 4'hF, rdata, resp);
      compare_word($sformatf("ROM response word %0d", i), 64'(resp), 64'(RespAck));
      compare_word($sformatf("ROM word %0d", i), 64'(rdata), 64'(rom_image[i]));
    end
    bus_cycle(1'b1, RomBase + 32'h8, $urandom, 4'hF, rdata, resp);
    compare_word("ROM write response", 64'(resp), 64'(RespErr));
    bus_cycle(1'b0, RomBase + 32'h8, '0, 4'hF, rdata, resp);
    compare_word("ROM word 2 after write", 64'(rdata), 64'(rom_image[2]));
    report_test("boot ROM", err_start);
  endtask

  task automatic ram_byte_lanes();
    int          err_start;
    int          slot;
    int          ram_idx [RamSlots];
    logic [31:0] ram_model [RamSlots];
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [3:0]  sel;
    resp_e       resp;
    err_start = errors + proto_errors;
    // Full-word writes first, the array has no reset value
    for (int s = 0; s < RamSlots; s++) begin
      ram_idx[s]   = s * 64 + int'($urandom % 64);
      ram_model[s] = $urandom;
      bus_cycle(1'b1, RamBase + 32'(4 * ram_idx[s]), ram_model[s], 4'hF, rdata, resp);
      compare_word("RAM full write response", 64'(resp), 64'(RespAck));
    end
    for (int n = 0; n < 32; n++) begin
      slot            = int'($urandom % RamSlots);
      wdata           = $urandom;
      sel             = 4'($urandom);
      ram_model[slot] = merge_lanes(ram_model[slot], wdata, sel);
      bus_cycle(1'b1, RamBase + 32'(4 * ram_idx[slot]), wdata, sel, rdata, resp);
      compare_word("RAM lane write response", 64'(resp), 64'(RespAck));
    end
    for (int s = 0; s < RamSlots; s++) begin
      bus_cycle(1'b0, RamBase + 32'(4 * ram_idx[s]), '0, 4'hF, rdata, resp);
      compare_word($sformatf("RAM word %0d", ram_idx[s]), 64'(rdata), 64'(ram_model[s]));
    end
    report_test("scratch RAM", err_start);
  endtask

  task automatic unmapped_errors();
    int          err_start;
    logic [31:0] addrs [8];
    logic [31:0] rdata;
    resp_e       resp;
    err_start = errors + proto_errors;
    addrs[0] = 32'h4000_0000;
    addrs[1] = RomBase + 32'h40;
    addrs[2] = RamBase + 32'h1000;
    addrs[3] = ClintBase + 32'h0001_0000;
    for (int i = 4; i < 8; i++) begin
      addrs[i] = 32'h4000_0000 | ($urandom & 32'h3FFF_FFFC);
    end
    for (int i = 0; i < 8; i++) begin
      bus_cycle(i[0], addrs[i], $urandom, 4'hF, rdata, resp);
      compare_word($sformatf("response at unmapped %h", addrs[i]), 64'(resp), 64'(RespErr));
    end
    report_test("unmapped addresses", err_start);
  endtask

  task automatic clint_registers();
    int          err_start;
    int          edges_start;
    int          guard;
    int          polls;
    bit          seen_high;
    logic [63:0] m0;
    logic [63:0] m1;
    logic [31:0] target;
    logic [31:0] cmp_addr;
    logic [31:0] rdata;
    logic [NumHarts-1:0] irq_now;
    resp_e       resp;
    err_start = errors + proto_errors;
    for (int h = 0; h < NumHarts; h++) begin
      bus_cycle(1'b1, ClintBase + 32'(4 * h), 32'h1, 4'hF, rdata, resp);
      compare_word($sformatf("ipi_o with msip %0d set", h), 64'(ipi_o), 64'(1 << h));
      bus_cycle(1'b1, ClintBase + 32'(4 * h), 32'h0, 4'hF, rdata, resp);
      compare_word($sformatf("ipi_o with msip %0d clear", h), 64'(ipi_o), 64'(0));
    end
    // mtime advances once per two rtc rising edges
    rtc_run = 1'b1;
    read_mtime(m0);
    edges_start = rtc_rises;
    guard       = 0;
    while (rtc_rises < edges_start + 2 * RtcPairs && guard < 200) begin
      @(negedge clk_i);
      guard++;
    end
    repeat (5) @(negedge clk_i);
    read_mtime(m1);
    check_within("mtime advance", m1 - m0, 64'(RtcPairs - 1), 64'(RtcPairs + 1));
    for (int h = 0; h < NumHarts; h++) begin
      cmp_addr = MtimecmpLo + 32'(8 * h);
      bus_cycle(1'b0, MtimeLo, '0, 4'hF, rdata, resp);
      target = rdata + 32'd3;
      bus_cycle(1'b1, cmp_addr + 32'd4, 32'h0, 4'hF, rdata, resp);
      bus_cycle(1'b1, cmp_addr, target, 4'hF, rdata, resp);
      seen_high = 1'b0;
      polls     = 0;
      // irq sampled in the same clock that the mtime read captures
      while (!seen_high && polls < 60) begin
        irq_now = timer_irq_o;
        bus_cycle(1'b0, MtimeLo, '0, 4'hF, rdata, resp);
        compare_word($sformatf("timer_irq_o at mtime %0d", rdata), 64'(irq_now),
                     (rdata >= target) ? 64'(1 << h) : 64'(0));
        seen_high = irq_now[h];
        polls++;
      end
      compare_word($sformatf("timer_irq_o %0d raised", h), 64'(seen_high), 64'(1));
      bus_cycle(1'b1, cmp_addr + 32'd4, 32'hFFFF_FFFF, 4'hF, rdata, resp);
      bus_cycle(1'b1, cmp_addr, 32'hFFFF_FFFF, 4'hF, rdata, resp);
      compare_word("timer_irq_o after mtimecmp reset", 64'(timer_irq_o), 64'(0));
    end
    report_test("CLINT", err_start);
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < TimeoutCycles) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: tests did not finish within %0d clock cycles", TimeoutCycles);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : main
    errors       = 0;
    proto_errors = 0;
    checks       = 0;
    tests_run    = 0;
    rtc_run      = 1'b0;
    ndmreset_n   = 1'b0;
    wb_cyc_i     = 1'b0;
    wb_stb_i     = 1'b0;
    wb_we_i      = 1'b0;
    wb_adr_i     = '0;
    wb_dat_i     = '0;
    wb_sel_i     = '0;
    debug_req_i  = '1;
    void'($urandom(Seed));
    $readmemh("verilog/boot_rom.hex", rom_image);
    repeat (3) @(negedge clk_i);
    ndmreset_n = 1'b1;
    reset_and_debug_gate();
    rom_reads();
    ram_byte_lanes();
    unmapped_errors();
    clint_registers();
    repeat (2) @(negedge clk_i);
    $display("Tests run: %0d, checks: %0d, errors: %0d", tests_run, checks,
             errors + proto_errors);
    if (errors + proto_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
verilog/soc_pkg.sv
verilog/wb_if.sv
verilog/wb_addr_decoder.sv
verilog/clint_timer.sv
verilog/boot_rom.sv
verilog/scratch_ram.sv
verilog/debug_req_gate.sv
verilog/soc_subsys_top.sv
tests/tb_soc_subsys.sv

//--- verilog/boot_rom.hex
// One 32-bit word per line in hex, word index 0 to 15 from the ROM base
f1402573
020002b7
00a28293
0002a023
00000597
03c58593
80000637
00b62023
00c62223
10500073
ffdff06f
00000013
00000013
deadbeef
0badc0de
5a5aa5a5

//--- verilog/boot_rom.sv
// Boot ROM on Wishbone, contents loaded from the boot image
module boot_rom #(
  parameter int unsigned ROM_WORDS = 16
) (
  input  logic clk_i,
  input  logic ndmreset_n,
  wb_if.slave  bus
);

  localparam int unsigned IdxWidth = $clog2(ROM_WORDS);

  logic [soc_pkg::DataWidth-1:0] mem [ROM_WORDS];
  logic [IdxWidth-1:0]           word_idx;
  logic                          req;
  logic                          ack_q;
  logic                          err_q;
  logic [soc_pkg::DataWidth-1:0] dat_q;

  initial begin
    $readmemh("verilog/boot_rom.hex", mem);
  end

  assign word_idx = bus.adr[IdxWidth+1:2];
  assign req      = bus.cyc & bus.stb & ~ack_q & ~err_q;

  always_ff @(posedge clk_i) begin
    if (req) begin
      dat_q <= mem[word_idx];
    end
  end

  // Writes are refused with err
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= req & ~bus.we;
      err_q <= req & bus.we;
    end
  end

  assign bus.dat_r = dat_q;
  assign bus.ack   = ack_q;
  assign bus.err   = err_q;

endmodule

//--- verilog/clint_timer.sv
// CLINT with mtime, per-hart mtimecmp and msip, rtc synchronizer and divide-by-two tick
module clint_timer #(
  parameter int unsigned NUM_HARTS = 2
) (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic                 rtc_i,
  wb_if.slave                  bus,
  output logic [NUM_HARTS-1:0] timer_irq_o,
  output logic [NUM_HARTS-1:0] ipi_o
);

  logic [1:0]                    rtc_sync_q;
  logic                          rtc_prev_q;
  logic                          rtc_rise;
  logic                          rtc_div_q;
  logic                          tick;

  logic [63:0]                   mtime_q;
  logic [63:0]                   mtimecmp_q [NUM_HARTS];
  logic [NUM_HARTS-1:0]          msip_q;

  logic [15:0]                   offset;
  logic                          req;
  logic                          wr;
  logic                          ack_q;
  logic [soc_pkg::DataWidth-1:0] rdata;
  logic [soc_pkg::DataWidth-1:0] dat_q;

  function automatic logic [15:0] msip_addr(int unsigned h);
    return soc_pkg::ClintMsipOffset + 16'(4 * h);
  endfunction

  // Low word of mtimecmp, high word sits 4 bytes above
  function automatic logic [15:0] cmp_addr(int unsigned h);
    return soc_pkg::ClintMtimecmpOffset + 16'(8 * h);
  endfunction

  // --------------------------------------------------
  // rtc sync and tick
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_sync_q <= 2'b00;
      rtc_prev_q <= 1'b0;
      rtc_div_q  <= 1'b0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[0], rtc_i};
      rtc_prev_q <= rtc_sync_q[1];
      if (rtc_rise) begin
        rtc_div_q <= ~rtc_div_q;
      end
    end
  end

  assign rtc_rise = rtc_sync_q[1] & ~rtc_prev_q;
  // Every second rtc edge
  assign tick     = rtc_rise & rtc_div_q;

  // --------------------------------------------------
  // Register file
  // --------------------------------------------------
  assign offset = bus.adr[15:0];
  assign req    = bus.cyc & bus.stb & ~ack_q;
  assign wr     = req & bus.we;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q <= '0;
      msip_q  <= '0;
      for (int h = 0; h < NUM_HARTS; h++) begin
        mtimecmp_q[h] <= '1;
      end
    end else begin
      mtime_q <= mtime_q + 64'(tick);
      // Bus writes win over the increment
      if (wr && offset == soc_pkg::ClintMtimeOffset) begin
        mtime_q[31:0] <= bus.dat_w;
      end
      if (wr && offset == soc_pkg::ClintMtimeOffset + 16'd4) begin
        mtime_q[63:32] <= bus.dat_w;
      end
      for (int h = 0; h < NUM_HARTS; h++) begin
        if (wr && offset == msip_addr(h)) begin
          msip_q[h] <= bus.dat_w[0];
        end
        if (wr && offset == cmp_addr(h)) begin
          mtimecmp_q[h][31:0] <= bus.dat_w;
        end
        if (wr && offset == cmp_addr(h) + 16'd4) begin
          mtimecmp_q[h][63:32] <= bus.dat_w;
        end
      end
    end
  end

  // Undefined offsets read as zero
  always_comb begin
    rdata = '0;
    if (offset == soc_pkg::ClintMtimeOffset) begin
      rdata = mtime_q[31:0];
    end
    if (offset == soc_pkg::ClintMtimeOffset + 16'd4) begin
      rdata = mtime_q[63:32];
    end
    for (int h = 0; h < NUM_HARTS; h++) begin
      if (offset == msip_addr(h)) begin
        rdata = {31'b0, msip_q[h]};
      end
      if (offset == cmp_addr(h)) begin
        rdata = mtimecmp_q[h][31:0];
      end
      if (offset == cmp_addr(h) + 16'd4) begin
        rdata = mtimecmp_q[h][63:32];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req) begin
      dat_q <= rdata;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  assign bus.dat_r = dat_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;

  // Interrupt outputs straight from the registers
  always_comb begin
    for (int h = 0; h < NUM_HARTS; h++) begin
      timer_irq_o[h] = (mtime_q >= mtimecmp_q[h]);
    end
  end

  assign ipi_o = msip_q;

endmodule

//--- verilog/debug_req_gate.sv
// Post-reset delay counter masking the per-hart debug requests
module debug_req_gate #(
  parameter int unsigned NUM_HARTS          = 2,
  parameter int unsigned DEBUG_DELAY_CYCLES = 500
) (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic [NUM_HARTS-1:0] debug_req_i,
  output logic [NUM_HARTS-1:0] debug_req_o
);

  // Counter keeps at least one bit for a zero delay
  localparam int unsigned CntWidth = $clog2(DEBUG_DELAY_CYCLES + 2);

  logic [CntWidth-1:0] cnt_q;
  logic                gate_open;

  assign gate_open = (cnt_q == '0);

  // Gives the harts time to run their boot code
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CntWidth'(DEBUG_DELAY_CYCLES);
    end else if (!gate_open) begin
      cnt_q <= cnt_q - CntWidth'(1);
    end
  end

  assign debug_req_o = gate_open ? debug_req_i : '0;

endmodule

//--- verilog/scratch_ram.sv
// Byte-writable single-port scratch RAM on Wishbone
module scratch_ram #(
  parameter int unsigned RAM_WORDS = 1024
) (
  input  logic clk_i,
  input  logic ndmreset_n,
  wb_if.slave  bus
);

  localparam int unsigned IdxWidth = $clog2(RAM_WORDS);

  logic [soc_pkg::DataWidth-1:0] mem [RAM_WORDS];
  logic [IdxWidth-1:0]           word_idx;
  logic                          req;
  logic                          ack_q;
  logic [soc_pkg::DataWidth-1:0] dat_q;

  // Word address wraps at the array size
  assign word_idx = IdxWidth'(bus.adr[soc_pkg::AddrWidth-1:2] % RAM_WORDS);
  assign req      = bus.cyc & bus.stb & ~ack_q;

  always_ff @(posedge clk_i) begin
    if (req && bus.we) begin
      for (int b = 0; b < soc_pkg::SelWidth; b++) begin
        if (bus.sel[b]) begin
          mem[word_idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
        end
      end
    end
    if (req) begin
      dat_q <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  assign bus.dat_r = dat_q;
  assign bus.ack   = ack_q;
  assign bus.err   = 1'b0;

endmodule

//--- verilog/soc_pkg.sv
// Bus widths, slave indices, address rule type, address map and CLINT register offsets
package soc_pkg;

  // --------------------------------------------------
  // Wishbone widths
  // --------------------------------------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SelWidth  = DataWidth / 8;

  // Decoder outputs, one per target
  typedef enum logic [1:0] {
    SlvRom   = 2'd0,
    SlvClint = 2'd1,
    SlvRam   = 2'd2
  } slave_idx_e;

  localparam int unsigned NumSlaves = 3;

  typedef struct packed {
    slave_idx_e           idx;
    logic [AddrWidth-1:0] start_addr;
    logic [AddrWidth-1:0] end_addr;
  } addr_rule_t;

  // --------------------------------------------------
  // Address map, end address exclusive
  // --------------------------------------------------
  localparam addr_rule_t AddrMap [NumSlaves] = '{
    '{idx: SlvRom,   start_addr: 32'h0001_0000, end_addr: 32'h0001_0000 + 32'h0000_0040},
    '{idx: SlvClint, start_addr: 32'h0200_0000, end_addr: 32'h0200_0000 + 32'h0001_0000},
    '{idx: SlvRam,   start_addr: 32'h8000_0000, end_addr: 32'h8000_0000 + 32'h0000_1000}
  };

  // CLINT offsets inside its 64 KiB window
  localparam logic [15:0] ClintMsipOffset     = 16'h0000;
  localparam logic [15:0] ClintMtimecmpOffset = 16'h4000;
  localparam logic [15:0] ClintMtimeOffset    = 16'hBFF8;

endpackage

//--- verilog/soc_subsys_top.sv
// Peripheral subsystem top with decoder, boot ROM, scratch RAM, CLINT and debug gate
module soc_subsys_top #(
  parameter int unsigned NUM_HARTS          = 2,
  parameter int unsigned DEBUG_DELAY_CYCLES = 500,
  parameter int unsigned RAM_WORDS          = 1024
) (
  input  logic                          clk_i,
  input  logic                          ndmreset_n,
  input  logic                          rtc_i,
  // Upstream Wishbone
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [soc_pkg::AddrWidth-1:0] wb_adr_i,
  input  logic [soc_pkg::DataWidth-1:0] wb_dat_i,
  input  logic [soc_pkg::SelWidth-1:0]  wb_sel_i,
  output logic [soc_pkg::DataWidth-1:0] wb_dat_o,
  output logic                          wb_ack_o,
  output logic                          wb_err_o,
  // Per-hart sideband
  input  logic [NUM_HARTS-1:0]          debug_req_i,
  output logic [NUM_HARTS-1:0]          debug_req_o,
  output logic [NUM_HARTS-1:0]          timer_irq_o,
  output logic [NUM_HARTS-1:0]          ipi_o
);

  // One bus per decoder output
  wb_if bus_slv [soc_pkg::NumSlaves] ();

  // --------------------------------------------------
  // Interconnect
  // --------------------------------------------------
  wb_addr_decoder i_decoder (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .up_cyc_i   ( wb_cyc_i   ),
    .up_stb_i   ( wb_stb_i   ),
    .up_we_i    ( wb_we_i    ),
    .up_adr_i   ( wb_adr_i   ),
    .up_dat_i   ( wb_dat_i   ),
    .up_sel_i   ( wb_sel_i   ),
    .up_dat_o   ( wb_dat_o   ),
    .up_ack_o   ( wb_ack_o   ),
    .up_err_o   ( wb_err_o   ),
    .slv_o      ( bus_slv    )
  );

  // --------------------------------------------------
  // Targets
  // --------------------------------------------------
  boot_rom i_boot_rom (
    .clk_i      ( clk_i                     ),
    .ndmreset_n ( ndmreset_n                ),
    .bus        ( bus_slv[soc_pkg::SlvRom]  )
  );

  scratch_ram #(
    .RAM_WORDS ( RAM_WORDS )
  ) i_scratch_ram (
    .clk_i      ( clk_i                     ),
    .ndmreset_n ( ndmreset_n                ),
    .bus        ( bus_slv[soc_pkg::SlvRam]  )
  );

  clint_timer #(
    .NUM_HARTS ( NUM_HARTS )
  ) i_clint (
    .clk_i       ( clk_i                      ),
    .ndmreset_n  ( ndmreset_n                 ),
    .rtc_i       ( rtc_i                      ),
    .bus         ( bus_slv[soc_pkg::SlvClint] ),
    .timer_irq_o ( timer_irq_o                ),
    .ipi_o       ( ipi_o                      )
  );

  debug_req_gate #(
    .NUM_HARTS          ( NUM_HARTS          ),
    .DEBUG_DELAY_CYCLES ( DEBUG_DELAY_CYCLES )
  ) i_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

//--- verilog/wb_addr_decoder.sv
// Rule-table Wishbone address decoder with error response for unmapped addresses
module wb_addr_decoder (
  input  logic                          clk_i,
  input  logic                          ndmreset_n,
  input  logic                          up_cyc_i,
  input  logic                          up_stb_i,
  input  logic                          up_we_i,
  input  logic [soc_pkg::AddrWidth-1:0] up_adr_i,
  input  logic [soc_pkg::DataWidth-1:0] up_dat_i,
  input  logic [soc_pkg::SelWidth-1:0]  up_sel_i,
  output logic [soc_pkg::DataWidth-1:0] up_dat_o,
  output logic                          up_ack_o,
  output logic                          up_err_o,
  wb_if.master                          slv_o [soc_pkg::NumSlaves]
);

  logic [soc_pkg::NumSlaves-1:0] hit;
  logic [soc_pkg::NumSlaves-1:0] slv_ack;
  logic [soc_pkg::NumSlaves-1:0] slv_err;
  logic [soc_pkg::DataWidth-1:0] slv_dat [soc_pkg::NumSlaves];
  logic                          miss_err_q;

  // Match the address against every rule
  always_comb begin
    hit = '0;
    for (int r = 0; r < soc_pkg::NumSlaves; r++) begin
      if (up_adr_i >= soc_pkg::AddrMap[r].start_addr &&
          up_adr_i <  soc_pkg::AddrMap[r].end_addr) begin
        hit[soc_pkg::AddrMap[r].idx] = 1'b1;
      end
    end
  end

  // Only the selected slave sees cyc and stb
  for (genvar s = 0; s < soc_pkg::NumSlaves; s++) begin : g_slv
    assign slv_o[s].cyc   = up_cyc_i & hit[s];
    assign slv_o[s].stb   = up_stb_i & hit[s];
    assign slv_o[s].we    = up_we_i;
    assign slv_o[s].adr   = up_adr_i;
    assign slv_o[s].dat_w = up_dat_i;
    assign slv_o[s].sel   = up_sel_i;
    assign slv_ack[s]     = slv_o[s].ack;
    assign slv_err[s]     = slv_o[s].err;
    assign slv_dat[s]     = slv_o[s].dat_r;
  end

  // Response path back to the master
  always_comb begin
    up_dat_o = '0;
    up_ack_o = 1'b0;
    up_err_o = miss_err_q;
    for (int s = 0; s < soc_pkg::NumSlaves; s++) begin
      if (hit[s]) begin
        up_dat_o = slv_dat[s];
        up_ack_o = slv_ack[s];
        up_err_o = miss_err_q | slv_err[s];
      end
    end
  end

  // Unmapped access answered with err one clock after stb
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      miss_err_q <= 1'b0;
    end else begin
      miss_err_q <= up_cyc_i & up_stb_i & ~(|hit) & ~miss_err_q;
    end
  end

endmodule

//--- verilog/wb_if.sv
// Wishbone classic bus interface with master and slave modports
interface wb_if;

  // Request side, driven by the master
  logic                            cyc;
  logic                            stb;
  logic                            we;
  logic [soc_pkg::AddrWidth-1:0]   adr;
  logic [soc_pkg::DataWidth-1:0]   dat_w;
  logic [soc_pkg::SelWidth-1:0]    sel;

  // Response side, driven by the slave
  logic [soc_pkg::DataWidth-1:0]   dat_r;
  logic                            ack;
  logic                            err;

  modport master (
    output cyc, stb, we, adr, dat_w, sel,
    input  dat_r, ack, err
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w, sel,
    output dat_r, ack, err
  );

endinterface
